// File: source/gb_bus_pkg.sv
package gb_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// one cpu address, seen as memory region or as io page
	typedef union packed {
		struct packed {
			logic [2:0]  region; // a15..a13, 8k each
			logic [12:0] offset;
		} mem;
		struct packed {
			logic [7:0] page;    // ff is io and hram
			logic [7:0] idx;
		} io;
	} gb_addr_u;

	// ------------------------------------------------------------------------
	// memory map
	localparam logic [2:0] REGION_ROM_LO = 3'd0;  // 0000-7fff cart rom
	localparam logic [2:0] REGION_ROM_HI = 3'd3;
	localparam logic [2:0] REGION_CRAM   = 3'd5;  // a000-bfff cart ram
	localparam logic [2:0] REGION_WRAM   = 3'd6;  // c000-dfff
	localparam logic [2:0] REGION_ECHO   = 3'd7;  // e000-fdff mirrors wram

	localparam logic [7:0] PAGE_IO  = 8'hFF;
	localparam logic [7:0] PAGE_OAM = 8'hFE;      // first page past the echo

	// io page indices
	localparam logic [7:0] IDX_P1     = 8'h00;
	localparam logic [7:0] IDX_IF     = 8'h0F;
	localparam logic [7:0] IDX_KEY1   = 8'h4D;
	localparam logic [7:0] IDX_SVBK   = 8'h70;
	localparam logic [7:0] IDX_FF72   = 8'h72;
	localparam logic [7:0] IDX_FF73   = 8'h73;
	localparam logic [7:0] IDX_FF74   = 8'h74;
	localparam logic [7:0] IDX_FF75   = 8'h75;
	localparam logic [7:0] IDX_IE     = 8'hFF;
	localparam logic [7:0] HRAM_FIRST = 8'h80;

	// ------------------------------------------------------------------------
	// interrupts, vblank lcd timer serial joypad from bit 0 up
	localparam int         NUM_IRQ      = 5;
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;

	localparam int                     WRAM_BANK_W     = 3;
	localparam logic [WRAM_BANK_W-1:0] WRAM_RESET_BANK = 3'd1;
	localparam int                     HRAM_AW         = 7;

	// cart open bus
	localparam int                        OPEN_BUS_CNT_W = 3;
	localparam logic [OPEN_BUS_CNT_W-1:0] OPEN_BUS_DECAY = 3'd4;
	localparam logic [DATA_W-1:0]         BUS_IDLE       = 8'hFF;

	// read source held by the decoder
	localparam int               SRC_W    = 3;
	localparam logic [SRC_W-1:0] SRC_NONE = 3'd0;
	localparam logic [SRC_W-1:0] SRC_WRAM = 3'd1;
	localparam logic [SRC_W-1:0] SRC_HRAM = 3'd2;
	localparam logic [SRC_W-1:0] SRC_IRQ  = 3'd3;
	localparam logic [SRC_W-1:0] SRC_SYS  = 3'd4;
	localparam logic [SRC_W-1:0] SRC_CART = 3'd5;

endpackage

// File: source/gb_bus_decode.sv
module gb_bus_decode (
	input  logic                          clk_sys,
	input  logic                          reset_ss,
	input  logic                          gbc_mode_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                          cpu_rd_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] wram_rdata_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] hram_rdata_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] irq_rdata_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] sys_rdata_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cart_rdata_i,
	output logic                          wram_sel_o,
	output logic                          svbk_sel_o,
	output logic                          hram_sel_o,
	output logic                          irq_sel_o,
	output logic                          sys_sel_o,
	output logic                          cart_sel_o,
	output logic [gb_bus_pkg::DATA_W-1:0] cpu_rdata_o
);

	gb_bus_pkg::gb_addr_u          addr;
	logic                          io_page;
	logic [gb_bus_pkg::SRC_W-1:0]  src_nxt;
	logic [gb_bus_pkg::SRC_W-1:0]  src_q;   // source of the last read

	assign addr    = cpu_addr_i;
	assign io_page = (addr.io.page == gb_bus_pkg::PAGE_IO);

	// ------------------------------------------------------------------------
	// region selects

	// c000-dfff plus echo, oam and io pages are not mirrored
	assign wram_sel_o = (addr.mem.region == gb_bus_pkg::REGION_WRAM) ||
		((addr.mem.region == gb_bus_pkg::REGION_ECHO) && (addr.io.page < gb_bus_pkg::PAGE_OAM));

	assign cart_sel_o = (addr.mem.region inside
		{[gb_bus_pkg::REGION_ROM_LO:gb_bus_pkg::REGION_ROM_HI]}) ||
		(addr.mem.region == gb_bus_pkg::REGION_CRAM);

	// ff80-fffe, ffff belongs to ie
	assign hram_sel_o = io_page && (addr.io.idx >= gb_bus_pkg::HRAM_FIRST) &&
		(addr.io.idx != gb_bus_pkg::IDX_IE);
	assign irq_sel_o  = io_page && ((addr.io.idx == gb_bus_pkg::IDX_IF) ||
		(addr.io.idx == gb_bus_pkg::IDX_IE));
	assign svbk_sel_o = io_page && gbc_mode_i && (addr.io.idx == gb_bus_pkg::IDX_SVBK);

	always_comb begin
		sys_sel_o = 1'b0;
		if (io_page) begin
			case (addr.io.idx)
				gb_bus_pkg::IDX_P1:   sys_sel_o = 1'b1;  // present in both modes
				gb_bus_pkg::IDX_KEY1,
				gb_bus_pkg::IDX_FF72,
				gb_bus_pkg::IDX_FF73,
				gb_bus_pkg::IDX_FF74,
				gb_bus_pkg::IDX_FF75: sys_sel_o = gbc_mode_i; // colour only
				default:              sys_sel_o = 1'b0;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// read source, latched at the strobe

	always_comb begin
		if (wram_sel_o || svbk_sel_o)
			src_nxt = gb_bus_pkg::SRC_WRAM;  // bank reg reads via wram port
		else if (hram_sel_o)
			src_nxt = gb_bus_pkg::SRC_HRAM;
		else if (irq_sel_o)
			src_nxt = gb_bus_pkg::SRC_IRQ;
		else if (sys_sel_o)
			src_nxt = gb_bus_pkg::SRC_SYS;
		else if (cart_sel_o)
			src_nxt = gb_bus_pkg::SRC_CART;
		else
			src_nxt = gb_bus_pkg::SRC_NONE; // vram, oam, unused io
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			src_q <= gb_bus_pkg::SRC_NONE;
		else if (cpu_rd_i)
			src_q <= src_nxt;
	end

	// block data is registered, so it lines up with src_q
	always_comb begin
		case (src_q)
			gb_bus_pkg::SRC_WRAM: cpu_rdata_o = wram_rdata_i;
			gb_bus_pkg::SRC_HRAM: cpu_rdata_o = hram_rdata_i;
			gb_bus_pkg::SRC_IRQ:  cpu_rdata_o = irq_rdata_i;
			gb_bus_pkg::SRC_SYS:  cpu_rdata_o = sys_rdata_i;
			gb_bus_pkg::SRC_CART: cpu_rdata_o = cart_rdata_i;
			default:              cpu_rdata_o = gb_bus_pkg::BUS_IDLE;
		endcase
	end

endmodule

// File: source/gb_irq_ctrl.sv
module gb_irq_ctrl (
	input  logic                           clk_sys,
	input  logic                           reset_ss,
	input  logic                           irq_sel_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0]  cpu_addr_i,
	input  logic                           cpu_wr_i,
	input  logic                           cpu_rd_i,
	input  logic [gb_bus_pkg::DATA_W-1:0]  cpu_wdata_i,
	input  logic                           irq_vblank_i,
	input  logic                           irq_lcd_i,
	input  logic                           irq_timer_i,
	input  logic                           irq_serial_i,
	input  logic [3:0]                     joy_din_i,
	input  logic                           irq_ack_i,
	output logic [gb_bus_pkg::DATA_W-1:0]  irq_rdata_o,
	output logic                           irq_pending_o,
	output logic [gb_bus_pkg::DATA_W-1:0]  irq_vec_o
);

	gb_bus_pkg::gb_addr_u            addr;
	logic [gb_bus_pkg::NUM_IRQ-1:0]  if_q;
	logic [gb_bus_pkg::DATA_W-1:0]   ie_q;      // all 8 bits kept
	logic [gb_bus_pkg::NUM_IRQ-2:0]  ev_now;
	logic [gb_bus_pkg::NUM_IRQ-2:0]  ev_prev;
	logic [3:0]                      joy_s1;
	logic [3:0]                      joy_s2;
	logic [gb_bus_pkg::NUM_IRQ-1:0]  rise;
	logic [gb_bus_pkg::NUM_IRQ-1:0]  active;
	logic [gb_bus_pkg::NUM_IRQ-1:0]  ack_mask;
	logic [gb_bus_pkg::DATA_W-1:0]   vec_k;
	logic                            found;
	logic                            wr_if;
	logic                            wr_ie;

	assign addr   = cpu_addr_i;
	assign ev_now = {irq_serial_i, irq_timer_i, irq_lcd_i, irq_vblank_i};

	// joypad lines are active low, any line going down raises bit 4
	assign rise   = {|(joy_s2 & ~joy_s1), ev_now & ~ev_prev};
	assign active = ie_q[gb_bus_pkg::NUM_IRQ-1:0] & if_q;
	assign wr_if  = irq_sel_i && cpu_wr_i && (addr.io.idx == gb_bus_pkg::IDX_IF);
	assign wr_ie  = irq_sel_i && cpu_wr_i && (addr.io.idx == gb_bus_pkg::IDX_IE);

	assign irq_pending_o = |active;

	// fixed priority, bit 0 wins
	always_comb begin
		irq_vec_o = '0;
		ack_mask  = '0;
		found     = 1'b0;
		vec_k     = gb_bus_pkg::IRQ_VEC_BASE;
		for (int k = 0; k < gb_bus_pkg::NUM_IRQ; k++) begin
			if (active[k] && !found) begin
				irq_vec_o   = vec_k;
				ack_mask[k] = 1'b1;
				found       = 1'b1;
			end
			vec_k = vec_k + gb_bus_pkg::IRQ_VEC_STEP;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_q    <= '0;
			ie_q    <= '0;
			ev_prev <= '0;
			joy_s1  <= '0;
			joy_s2  <= '0;
		end else begin
			ev_prev <= ev_now;
			joy_s1  <= joy_din_i;       // two flops, async pad input
			joy_s2  <= joy_s1;
			if (wr_if)
				if_q <= cpu_wdata_i[gb_bus_pkg::NUM_IRQ-1:0]; // cpu beats events
			else if (irq_ack_i)
				if_q <= (if_q | rise) & ~ack_mask;
			else
				if_q <= if_q | rise;
			if (wr_ie)
				ie_q <= cpu_wdata_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (irq_sel_i && cpu_rd_i) begin
			if (addr.io.idx == gb_bus_pkg::IDX_IF)
				irq_rdata_o <= {{(gb_bus_pkg::DATA_W - gb_bus_pkg::NUM_IRQ){1'b1}}, if_q};
			else
				irq_rdata_o <= ie_q;
		end
	end

endmodule

// File: source/gb_internal_ram.sv
module gb_internal_ram (
	input  logic                          clk_sys,
	input  logic                          reset_ss,
	input  logic                          gbc_mode_i,
	input  logic                          wram_sel_i,
	input  logic                          hram_sel_i,
	input  logic                          svbk_sel_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                          cpu_wr_i,
	input  logic                          cpu_rd_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cpu_wdata_i,
	output logic [gb_bus_pkg::DATA_W-1:0] wram_rdata_o,
	output logic [gb_bus_pkg::DATA_W-1:0] hram_rdata_o
);

	gb_bus_pkg::gb_addr_u                 addr;
	logic [gb_bus_pkg::DATA_W-1:0]        wram_mem [0:(1 << (gb_bus_pkg::WRAM_BANK_W + 12)) - 1];
	logic [gb_bus_pkg::DATA_W-1:0]        hram_mem [0:(1 << gb_bus_pkg::HRAM_AW) - 2];
	logic [gb_bus_pkg::WRAM_BANK_W-1:0]   bank_q;    // svbk
	logic [gb_bus_pkg::WRAM_BANK_W-1:0]   bank_eff;
	logic [gb_bus_pkg::WRAM_BANK_W+11:0]  wram_addr;
	logic [gb_bus_pkg::HRAM_AW-1:0]       hram_addr;

	assign addr = cpu_addr_i;

	// c000-cfff always bank 0, d000-dfff switchable in colour mode only
	assign bank_eff  = !addr.mem.offset[12] ? '0 :
		gbc_mode_i ? bank_q : gb_bus_pkg::WRAM_RESET_BANK;
	assign wram_addr = {bank_eff, addr.mem.offset[11:0]};
	assign hram_addr = addr.io.idx[gb_bus_pkg::HRAM_AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			bank_q <= gb_bus_pkg::WRAM_RESET_BANK;
		else if (svbk_sel_i && cpu_wr_i) begin
			if (cpu_wdata_i[gb_bus_pkg::WRAM_BANK_W-1:0] == '0)
				bank_q <= gb_bus_pkg::WRAM_RESET_BANK; // 0 maps to 1
			else
				bank_q <= cpu_wdata_i[gb_bus_pkg::WRAM_BANK_W-1:0];
		end
	end

	// work ram, bank register shares the read port
	always_ff @(posedge clk_sys) begin
		if (wram_sel_i && cpu_wr_i)
			wram_mem[wram_addr] <= cpu_wdata_i;
		if (wram_sel_i && cpu_rd_i)
			wram_rdata_o <= wram_mem[wram_addr];
		else if (svbk_sel_i && cpu_rd_i)
			wram_rdata_o <= {{(gb_bus_pkg::DATA_W - gb_bus_pkg::WRAM_BANK_W){1'b1}}, bank_q};
	end

	// high ram ff80-fffe
	always_ff @(posedge clk_sys) begin
		if (hram_sel_i && cpu_wr_i)
			hram_mem[hram_addr] <= cpu_wdata_i;
		if (hram_sel_i && cpu_rd_i)
			hram_rdata_o <= hram_mem[hram_addr];
	end

endmodule

// File: source/gb_sys_regs.sv
module gb_sys_regs (
	input  logic                          clk_sys,
	input  logic                          reset_ss,
	input  logic                          sys_sel_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                          cpu_wr_i,
	input  logic                          cpu_rd_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cpu_wdata_i,
	input  logic [3:0]                    joy_din_i,
	input  logic                          cpu_stop_i,
	output logic [gb_bus_pkg::DATA_W-1:0] sys_rdata_o,
	output logic [1:0]                    joy_p54_o,
	output logic                          speed_o
);

	gb_bus_pkg::gb_addr_u           addr;
	logic                           wr;
	logic [1:0]                     p54_q;     // p14/p15 row select
	logic                           speed_q;   // double speed active
	logic                           prepare_q;
	logic [gb_bus_pkg::DATA_W-1:0]  ff72_q;
	logic [gb_bus_pkg::DATA_W-1:0]  ff73_q;
	logic [gb_bus_pkg::DATA_W-1:0]  ff74_q;
	logic [2:0]                     ff75_q;    // only bits 6..4 exist

	assign addr      = cpu_addr_i;
	assign wr        = sys_sel_i && cpu_wr_i;
	assign joy_p54_o = p54_q;
	assign speed_o   = speed_q;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			p54_q     <= '0;
			speed_q   <= 1'b0;
			prepare_q <= 1'b0;
			ff72_q    <= '0;
			ff73_q    <= '0;
			ff74_q    <= '0;
			ff75_q    <= '0;
		end else begin
			if (wr) begin
				case (addr.io.idx)
					gb_bus_pkg::IDX_P1:   p54_q     <= cpu_wdata_i[5:4];
					gb_bus_pkg::IDX_KEY1: prepare_q <= cpu_wdata_i[0];
					gb_bus_pkg::IDX_FF72: ff72_q    <= cpu_wdata_i;
					gb_bus_pkg::IDX_FF73: ff73_q    <= cpu_wdata_i;
					gb_bus_pkg::IDX_FF74: ff74_q    <= cpu_wdata_i;
					gb_bus_pkg::IDX_FF75: ff75_q    <= cpu_wdata_i[6:4];
					default: ;
				endcase
			end
			// stop with prepare armed flips the speed and disarms
			if (prepare_q && cpu_stop_i) begin
				speed_q   <= ~speed_q;
				prepare_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sys_sel_i && cpu_rd_i) begin
			case (addr.io.idx)
				gb_bus_pkg::IDX_P1:   sys_rdata_o <= {2'b11, p54_q, joy_din_i};
				gb_bus_pkg::IDX_KEY1: sys_rdata_o <= {speed_q, 6'h3F, prepare_q};
				gb_bus_pkg::IDX_FF72: sys_rdata_o <= ff72_q;
				gb_bus_pkg::IDX_FF73: sys_rdata_o <= ff73_q;
				gb_bus_pkg::IDX_FF74: sys_rdata_o <= ff74_q;
				gb_bus_pkg::IDX_FF75: sys_rdata_o <= {1'b1, ff75_q, 4'hF};
				default:              sys_rdata_o <= gb_bus_pkg::BUS_IDLE;
			endcase
		end
	end

endmodule

// File: source/gb_cart_bus.sv
module gb_cart_bus (
	input  logic                          clk_sys,
	input  logic                          reset_ss,
	input  logic                          cart_sel_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                          cpu_rd_i,
	input  logic                          cpu_wr_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cpu_wdata_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cart_rdata_i,
	input  logic                          cart_oe_i,
	output logic [gb_bus_pkg::ADDR_W-2:0] cart_addr_o,
	output logic                          cart_a15_o,
	output logic                          cart_rd_o,
	output logic                          cart_wr_o,
	output logic                          cart_cs_n_o,
	output logic [gb_bus_pkg::DATA_W-1:0] cart_wdata_o,
	output logic [gb_bus_pkg::DATA_W-1:0] cart_bus_rdata_o
);

	gb_bus_pkg::gb_addr_u                   addr;
	logic                                   driven;   // cart actually drives the bus
	logic [gb_bus_pkg::DATA_W-1:0]          live;
	logic [gb_bus_pkg::DATA_W-1:0]          ob_data_q;
	logic [gb_bus_pkg::OPEN_BUS_CNT_W-1:0]  ob_cnt_q;

	assign addr         = cpu_addr_i;
	assign cart_addr_o  = cpu_addr_i[gb_bus_pkg::ADDR_W-2:0];
	assign cart_a15_o   = cpu_addr_i[gb_bus_pkg::ADDR_W-1];
	assign cart_wdata_o = cpu_wdata_i;
	assign cart_rd_o    = cart_sel_i && cpu_rd_i;
	assign cart_wr_o    = cart_sel_i && cpu_wr_i;
	// cs only for a000-bfff, rom uses a15
	assign cart_cs_n_o  = !((addr.mem.region == gb_bus_pkg::REGION_CRAM) &&
		(cart_rd_o || cart_wr_o));

	assign driven = cart_rd_o && cart_oe_i;
	assign live   = driven ? cart_rdata_i : ob_data_q; // else last value floats

	// ------------------------------------------------------------------------
	// open bus, bus capacitance holds the byte until the pull-ups win
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ob_data_q <= '0;
			ob_cnt_q  <= '0;
		end else begin
			ob_data_q <= live;
			if (driven)
				ob_cnt_q <= '0;
			else if (~&ob_cnt_q) begin  // saturate at 7
				ob_cnt_q <= ob_cnt_q + 1'b1;
				if (ob_cnt_q == gb_bus_pkg::OPEN_BUS_DECAY)
					ob_data_q <= gb_bus_pkg::BUS_IDLE;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_rd_o)
			cart_bus_rdata_o <= live;
	end

endmodule

// File: source/gb_bus_top.sv
module gb_bus_top (
	input  logic                          clk_sys,
	input  logic                          reset_ss,
	input  logic                          gbc_mode_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0] cpu_addr_i,
	input  logic                          cpu_rd_i,
	input  logic                          cpu_wr_i,
	input  logic [gb_bus_pkg::DATA_W-1:0] cpu_wdata_i,
	output logic [gb_bus_pkg::DATA_W-1:0] cpu_rdata_o,
	input  logic                          cpu_stop_i,
	input  logic                          irq_vblank_i,
	input  logic                          irq_lcd_i,
	input  logic                          irq_timer_i,
	input  logic                          irq_serial_i,
	input  logic                          irq_ack_i,
	output logic                          irq_pending_o,
	output logic [gb_bus_pkg::DATA_W-1:0] irq_vec_o,
	input  logic [3:0]                    joy_din_i,
	output logic [1:0]                    joy_p54_o,
	output logic                          speed_o,
	output logic [gb_bus_pkg::ADDR_W-2:0] cart_addr_o,
	output logic                          cart_a15_o,
	output logic                          cart_rd_o,
	output logic                          cart_wr_o,
	output logic                          cart_cs_n_o,
	output logic [gb_bus_pkg::DATA_W-1:0] cart_wdata_o,
	input  logic [gb_bus_pkg::DATA_W-1:0] cart_rdata_i,
	input  logic                          cart_oe_i
);

	// region selects
	logic wram_sel, svbk_sel, hram_sel, irq_sel, sys_sel, cart_sel;
	// registered block read data
	logic [gb_bus_pkg::DATA_W-1:0] wram_rdata, hram_rdata, irq_rdata, sys_rdata, cart_bus_rdata;

	gb_bus_decode gb_bus_decode_i (
		.clk_sys, .reset_ss, .gbc_mode_i, .cpu_addr_i, .cpu_rd_i,
		.wram_rdata_i(wram_rdata), .hram_rdata_i(hram_rdata), .irq_rdata_i(irq_rdata),
		.sys_rdata_i(sys_rdata), .cart_rdata_i(cart_bus_rdata),
		.wram_sel_o(wram_sel), .svbk_sel_o(svbk_sel), .hram_sel_o(hram_sel),
		.irq_sel_o(irq_sel), .sys_sel_o(sys_sel), .cart_sel_o(cart_sel), .cpu_rdata_o
	);

	gb_irq_ctrl gb_irq_ctrl_i (
		.clk_sys, .reset_ss, .irq_sel_i(irq_sel), .cpu_addr_i, .cpu_wr_i, .cpu_rd_i,
		.cpu_wdata_i, .irq_vblank_i, .irq_lcd_i, .irq_timer_i, .irq_serial_i, .joy_din_i,
		.irq_ack_i, .irq_rdata_o(irq_rdata), .irq_pending_o, .irq_vec_o
	);

	gb_internal_ram gb_internal_ram_i (
		.clk_sys, .reset_ss, .gbc_mode_i, .wram_sel_i(wram_sel), .hram_sel_i(hram_sel),
		.svbk_sel_i(svbk_sel), .cpu_addr_i, .cpu_wr_i, .cpu_rd_i, .cpu_wdata_i,
		.wram_rdata_o(wram_rdata), .hram_rdata_o(hram_rdata)
	);

	gb_sys_regs gb_sys_regs_i (
		.clk_sys, .reset_ss, .sys_sel_i(sys_sel), .cpu_addr_i, .cpu_wr_i, .cpu_rd_i,
		.cpu_wdata_i, .joy_din_i, .cpu_stop_i, .sys_rdata_o(sys_rdata), .joy_p54_o, .speed_o
	);

	gb_cart_bus gb_cart_bus_i (
		.clk_sys, .reset_ss, .cart_sel_i(cart_sel), .cpu_addr_i, .cpu_rd_i, .cpu_wr_i,
		.cpu_wdata_i, .cart_rdata_i, .cart_oe_i, .cart_addr_o, .cart_a15_o, .cart_rd_o,
		.cart_wr_o, .cart_cs_n_o, .cart_wdata_o, .cart_bus_rdata_o(cart_bus_rdata)
	);

endmodule

// File: tests/gb_bus_props.sv
module gb_bus_props (
	input logic       clk_sys,
	input logic       reset_ss,
	input logic       cpu_wr_i,
	input logic       cart_rd_o,
	input logic       cart_wr_o,
	input logic       irq_pending_o,
	input logic [7:0] irq_vec_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// cart strobes are exclusive
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!(cart_rd_o && cart_wr_o))
		else $error("cart_rd_o and cart_wr_o high together");

	// vector is zero only with nothing pending
	pending_vs_vec: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_pending_o == (irq_vec_o != 8'h00))
		else $error("irq_pending_o disagrees with irq_vec_o");

	cart_wr_needs_cpu_wr: assert property (@(posedge clk_sys) disable iff (reset_ss)
		cart_wr_o |-> cpu_wr_i)
		else $error("cart_wr_o without cpu_wr_i");

endmodule

bind gb_bus_top gb_bus_props gb_bus_props_i (
	.clk_sys(clk_sys), .reset_ss(reset_ss), .cpu_wr_i(cpu_wr_i), .cart_rd_o(cart_rd_o),
	.cart_wr_o(cart_wr_o), .irq_pending_o(irq_pending_o), .irq_vec_o(irq_vec_o)
);

// File: tests/gb_bus_tb.sv
module gb_bus_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk_sys, reset_ss, gbc_mode_i, cpu_rd_i, cpu_wr_i, cpu_stop_i, irq_ack_i;
	logic irq_vblank_i, irq_lcd_i, irq_timer_i, irq_serial_i, irq_pending_o;
	logic cart_a15_o, cart_rd_o, cart_wr_o, cart_cs_n_o, cart_oe_i, speed_o, oe_en;
	logic [15:0] cpu_addr_i;
	logic [14:0] cart_addr_o;
	logic [7:0]  cpu_wdata_i, cpu_rdata_o, irq_vec_o, cart_wdata_o, cart_rdata_i;
	logic [3:0]  joy_din_i;
	logic [1:0]  joy_p54_o;
	integer      seed;

	// reference model state
	logic [7:0] m_wram [0:32767];
	bit         m_wram_ok [0:32767];  // written at least once
	logic [7:0] m_hram [0:126];
	logic [7:0] m_ie, m_ff72, m_ff73, m_ff74, m_ob, exp_rd;
	logic [4:0] m_if;
	logic [3:0] m_ev_prev, m_js1, m_js2;
	logic [2:0] m_bank, m_ff75, m_ob_cnt;
	logic [1:0] m_p54;
	logic       m_speed, m_prep;

	gb_bus_top gb_bus_top_i (.*);

	// cartridge answers with the low address byte scrambled
	assign cart_rdata_i = cart_addr_o[7:0] ^ 8'h5A;
	assign cart_oe_i    = cart_rd_o && oe_en;

	always #10 clk_sys = ~clk_sys;

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("error: %s is %h, expected %h", name, got, exp);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	function automatic logic [14:0] wram_idx(input logic [15:0] a);
		logic [2:0] bank;
		bank = !a[12] ? 3'd0 : (gbc_mode_i ? m_bank : 3'd1);
		return {bank, a[11:0]};
	endfunction

	function automatic bit is_cart(input logic [15:0] a);
		return (a < 16'h8000) || (a >= 16'hA000 && a < 16'hC000);
	endfunction

	function automatic logic [7:0] exp_vec();
		logic [4:0] act;
		act = m_ie[4:0] & m_if;
		for (int k = 0; k < gb_bus_pkg::NUM_IRQ; k++)
			if (act[k])
				return gb_bus_pkg::IRQ_VEC_BASE + 8'(k) * gb_bus_pkg::IRQ_VEC_STEP;
		return 8'h00;
	endfunction

	// expected byte for a read from the memory map
	function automatic logic [7:0] model_read(input logic [15:0] a, input logic [7:0] live);
		if (a >= 16'hC000 && a < 16'hFE00) return m_wram[wram_idx(a)];
		if (is_cart(a))                     return live;
		if (a >= 16'hFF80 && a < 16'hFFFF)  return m_hram[a[6:0]];
		if (a == 16'hFFFF)                  return m_ie;
		if (a == 16'hFF0F)                  return {3'b111, m_if};
		if (a == 16'hFF00)                  return {2'b11, m_p54, joy_din_i};
		if (!gbc_mode_i)                    return 8'hFF;
		case (a)
			16'hFF70: return {5'b11111, m_bank};
			16'hFF4D: return {m_speed, 6'h3F, m_prep};
			16'hFF72: return m_ff72;
			16'hFF73: return m_ff73;
			16'hFF74: return m_ff74;
			16'hFF75: return {1'b1, m_ff75, 4'hF};
			default:  return 8'hFF;
		endcase
	endfunction

	// model update at a rising edge using this cycle's inputs
	task automatic model_edge();
		logic [4:0] rise, act, ackm;
		logic [7:0] live;
		logic [15:0] a;
		logic [7:0] d;
		logic       drv, p_old;
		a = cpu_addr_i;
		d = cpu_wdata_i;
		if (reset_ss) begin
			m_ie      = 0;
			m_if      = 0;
			m_ev_prev = 0;
			m_js1     = 0;
			m_js2     = 0;
			m_bank    = 1;
			m_p54     = 0;
			m_speed   = 0;
			m_prep    = 0;
			m_ff72    = 0;
			m_ff73    = 0;
			m_ff74    = 0;
			m_ff75    = 0;
			m_ob      = 0;
			m_ob_cnt  = 0;
			return;
		end
		act  = m_ie[4:0] & m_if;
		ackm = act & ~(act - 5'd1);  // lowest set bit
		rise = {|(m_js2 & ~m_js1),
			{irq_serial_i, irq_timer_i, irq_lcd_i, irq_vblank_i} & ~m_ev_prev};
		drv  = is_cart(a) && cpu_rd_i && oe_en;
		live = drv ? (a[7:0] ^ 8'h5A) : m_ob;
		p_old = m_prep;
		if (cpu_rd_i)
			exp_rd = model_read(a, live);
		if (cpu_wr_i && a == 16'hFF0F)
			m_if = d[4:0];                  // cpu write beats events
		else if (irq_ack_i)
			m_if = (m_if | rise) & ~ackm;
		else
			m_if = m_if | rise;
		if (cpu_wr_i) begin
			if (a >= 16'hC000 && a < 16'hFE00) begin
				m_wram[wram_idx(a)]    = d;
				m_wram_ok[wram_idx(a)] = 1;
			end
			if (a >= 16'hFF80 && a < 16'hFFFF) m_hram[a[6:0]] = d;
			if (a == 16'hFFFF) m_ie = d;
			if (a == 16'hFF00) m_p54 = d[5:4];
			if (gbc_mode_i) begin
				if (a == 16'hFF70) m_bank = (d[2:0] == 0) ? 3'd1 : d[2:0];
				if (a == 16'hFF4D) m_prep = d[0];
				if (a == 16'hFF72) m_ff72 = d;
				if (a == 16'hFF73) m_ff73 = d;
				if (a == 16'hFF74) m_ff74 = d;
				if (a == 16'hFF75) m_ff75 = d[6:4];
			end
		end
		if (p_old && cpu_stop_i) begin
			m_speed = ~m_speed;
			m_prep  = 0;
		end
		m_ev_prev = {irq_serial_i, irq_timer_i, irq_lcd_i, irq_vblank_i};
		m_js2 = m_js1;
		m_js1 = joy_din_i;
		// open bus decays to ones after a few undriven cycles
		m_ob = live;
		if (drv)
			m_ob_cnt = 0;
		else if (m_ob_cnt != 3'd7) begin
			if (m_ob_cnt == gb_bus_pkg::OPEN_BUS_DECAY) m_ob = 8'hFF;
			m_ob_cnt = m_ob_cnt + 1;
		end
	endtask

	// cart pins follow the cpu address and strobes
	task automatic check_cart_pins();
		logic sel;
		logic cram;
		sel  = is_cart(cpu_addr_i);
		cram = (cpu_addr_i >= 16'hA000) && (cpu_addr_i < 16'hC000);
		check("cart_addr_o", cart_addr_o, cpu_addr_i[14:0]);
		check("cart_a15_o", cart_a15_o, cpu_addr_i[15]);
		check("cart_rd_o", cart_rd_o, sel && cpu_rd_i);
		check("cart_wr_o", cart_wr_o, sel && cpu_wr_i);
		check("cart_cs_n_o", cart_cs_n_o, !(cram && (cpu_rd_i || cpu_wr_i)));
		if (sel && cpu_wr_i)
			check("cart_wdata_o", cart_wdata_o, cpu_wdata_i);
	endtask

	// one bus cycle with outputs checked at the falling edge
	task automatic tick();
		@(posedge clk_sys);
		model_edge();
		@(negedge clk_sys);
		check("irq_pending_o", irq_pending_o, |(m_ie[4:0] & m_if));
		check("irq_vec_o", irq_vec_o, exp_vec());
		check("joy_p54_o", joy_p54_o, m_p54);
		check("speed_o", speed_o, m_speed);
		check_cart_pins();
	endtask

	task automatic bus_read(input logic [15:0] a);
		cpu_addr_i = a;
		cpu_rd_i   = 1;
		tick();
		cpu_rd_i   = 0;
		check("cpu_rdata_o", cpu_rdata_o, exp_rd);
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr_i  = a;
		cpu_wdata_i = d;
		cpu_wr_i    = 1;
		tick();
		cpu_wr_i    = 0;
	endtask

	task automatic apply_reset(input logic colour);
		gbc_mode_i = colour;
		reset_ss   = 1;
		repeat (4) tick();
		reset_ss   = 0;
	endtask

	// random wram and echo traffic plus the odd bank register access
	task automatic wram_traffic(input int n);
		logic [31:0] r;
		logic [15:0] a;
		for (int i = 0; i < n; i++) begin
			r = $random(seed);
			a = 16'hC000 + (r[15:0] & 16'h1FFF);
			if (r[16] && a < 16'hDE00) a = a + 16'h2000;  // echo mirror
			if (r[20:17] == 0)
				bus_write(16'hFF70, r[31:24]);
			else if (r[20:17] == 1)
				bus_read(16'hFF70);
			else if (r[21] || !m_wram_ok[wram_idx(a)])
				bus_write(a, r[31:24]);
			else
				bus_read(a);
		end
	endtask

	initial begin
		int n;
		seed         = 19;
		clk_sys      = 0;
		reset_ss     = 1;
		gbc_mode_i   = 1;
		cpu_addr_i   = 0;
		cpu_wdata_i  = 0;
		cpu_rd_i     = 0;
		cpu_wr_i     = 0;
		cpu_stop_i   = 0;
		irq_ack_i    = 0;
		irq_vblank_i = 0;
		irq_lcd_i    = 0;
		irq_timer_i  = 0;
		irq_serial_i = 0;
		joy_din_i    = 4'hF;
		oe_en        = 1;
		@(negedge clk_sys);
		apply_reset(1);

		// ----------------------------------------------------------------------
		wram_traffic(800);
		bus_write(16'hFF70, 8'h00);  // bank 0 stores 1
		bus_read(16'hFF70);
		check("cpu_rdata_o", cpu_rdata_o, 8'hF9);

		for (int i = 0; i < 127; i++)
			bus_write(16'hFF80 + 16'(i), 8'($random(seed)));
		for (int i = 0; i < 200; i++) begin
			n = $random(seed);
			if (n[8]) bus_write(16'hFF80 + 16'(n[6:0] % 127), n[31:24]);
			else      bus_read(16'hFF80 + 16'(n[6:0] % 127));
		end
		bus_write(16'hFFFF, 8'hA5);  // lands in ie and not in hram
		bus_read(16'hFFFF);
		bus_write(16'hFFFF, 8'h00);

		// ----------------------------------------------------------------------
		// interrupt events, enables and acknowledges
		for (int i = 0; i < 400; i++) begin
			n = $random(seed);
			{irq_serial_i, irq_timer_i, irq_lcd_i, irq_vblank_i} = n[3:0];
			case (n[6:4])
				0:       bus_write(16'hFFFF, n[15:8]);
				1:       bus_read(16'hFF0F);
				2:       bus_read(16'hFFFF);
				3:       bus_write(16'hFF0F, n[15:8]);
				4, 5: begin
					irq_ack_i = 1;
					tick();
					irq_ack_i = 0;
				end
				default: tick();
			endcase
		end
		{irq_serial_i, irq_timer_i, irq_lcd_i, irq_vblank_i} = 4'h0;
		tick();

		// ----------------------------------------------------------------------
		// joypad select and falling edge interrupt
		bus_write(16'hFF00, 8'h20);
		bus_read(16'hFF00);
		joy_din_i = 4'h9;
		bus_read(16'hFF00);
		bus_write(16'hFFFF, 8'h10);
		bus_write(16'hFF0F, 8'h00);
		joy_din_i = 4'h1;
		n = 0;
		while (!irq_pending_o) begin
			if (n == 10) fail_timeout("joypad interrupt");
			tick();
			n++;
		end
		bus_read(16'hFF0F);
		joy_din_i = 4'hF;

		// spare registers and speed switch
		for (int i = 0; i < 40; i++) begin
			n = $random(seed);
			if (n[8]) bus_write(16'hFF72 + 16'(n[1:0]), n[31:24]);
			else      bus_read(16'hFF72 + 16'(n[1:0]));
		end
		bus_write(16'hFF4D, 8'h01);
		bus_read(16'hFF4D);
		cpu_stop_i = 1;
		n = 0;
		while (!speed_o) begin
			if (n == 10) fail_timeout("speed switch");
			tick();
			n++;
		end
		cpu_stop_i = 0;
		bus_read(16'hFF4D);

		// ----------------------------------------------------------------------
		// cartridge, open bus and unmapped space
		for (int i = 0; i < 100; i++) begin
			n = $random(seed);
			oe_en = n[20];
			if (n[21]) bus_read(n[15] ? 16'hA000 + 16'(n[12:0]) : 16'(n[14:0]));
			else       bus_write(16'hA000 + 16'(n[12:0]), n[31:24]);
		end
		oe_en = 1;
		bus_read(16'h1234);
		oe_en = 0;
		bus_read(16'h4321);
		check("cpu_rdata_o", cpu_rdata_o, 8'h34 ^ 8'h5A);
		repeat (6) tick();
		bus_read(16'hA010);
		check("cpu_rdata_o", cpu_rdata_o, 8'hFF);
		oe_en = 1;
		bus_read(16'h8000);
		bus_read(16'hFE10);
		bus_read(16'hFF01);

		// ----------------------------------------------------------------------
		// monochrome mode
		apply_reset(0);
		wram_traffic(300);
		for (int i = 0; i < 4; i++)
			bus_read(16'hFF72 + 16'(i));
		bus_read(16'hFF4D);
		check("cpu_rdata_o", cpu_rdata_o, 8'hFF);

		$display("Everything OK");
		$finish;
	end

endmodule

// File: project.f
source/gb_bus_pkg.sv
source/gb_bus_decode.sv
source/gb_irq_ctrl.sv
source/gb_internal_ram.sv
source/gb_sys_regs.sv
source/gb_cart_bus.sv
source/gb_bus_top.sv
tests/gb_bus_props.sv
tests/gb_bus_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = gb_bus_tb
FILELIST  = project.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
